// ==== source/riscv_macros.svh ====
// width, register count and opcode constants for the rv64 core
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath widths
`define XLEN      64
`define INSTR_W   32
`define REG_COUNT 32
`define PC_W      30   // word address, byte bits 1:0 dropped
`define SHAMT_W   6    // rv64 shift amount

// major opcodes, instr[6:0]
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`endif

// ==== source/riscv_pkg.sv ====
// shared vector types, alu and immediate enums, decoded control struct
`default_nettype none
`include "riscv_macros.svh"

package riscv_pkg;

	typedef logic [`XLEN-1:0]               xlen_t;
	typedef logic [`INSTR_W-1:0]            instr_t;
	typedef logic [`PC_W-1:0]               word_addr_t;
	typedef logic [$clog2(`REG_COUNT)-1:0]  reg_idx_t;

	// encoding 0 is add, so a cleared control word means add
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [2:0] {
		imm_none,
		imm_i,
		imm_i_shamt, // slli, srli, srai
		imm_s,
		imm_b,
		imm_j
	} imm_kind_e;

	typedef struct packed {
		logic    jal;
		logic    jalr;
		logic    branch;
		logic    branch_ne;  // bne when set, beq otherwise
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    alu_src;    // immediate as operand b
		alu_op_e alu_op;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
// instruction decoder: control word, register indices and immediate
`default_nettype none
`include "riscv_macros.svh"

module instr_decoder (
	input  riscv_pkg::instr_t   instr,
	output riscv_pkg::ctrl_t    ctrl,
	output riscv_pkg::reg_idx_t rs1,
	output riscv_pkg::reg_idx_t rs2,
	output riscv_pkg::reg_idx_t rd,
	output riscv_pkg::xlen_t    imm
);
	import riscv_pkg::*;

	imm_kind_e  kind;
	logic [2:0] funct3;
	logic       alt;  // instr[30], sub and arithmetic right shift

	// funct3 to alu op, bit 30 only picks sub for register ops
	function automatic alu_op_e sel_op(input logic [2:0] f3, input logic alt_bit,
		input logic reg_op);
		alu_op_e op;
		case (f3)
			3'b000:  op = (reg_op && alt_bit) ? alu_sub : alu_add;
			3'b001:  op = alu_sll;
			3'b010:  op = alu_slt;
			3'b100:  op = alu_xor;
			3'b101:  op = alt_bit ? alu_sra : alu_srl;
			3'b110:  op = alu_or;
			3'b111:  op = alu_and;
			default: op = alu_add; // sltu not supported
		endcase
		return op;
	endfunction

	assign funct3 = instr[14:12];
	assign alt    = instr[30];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	always_comb begin
		ctrl = '0;
		kind = imm_none;
		case (instr[6:0])
			`OPC_JAL: begin
				ctrl.jal       = 1'b1;
				ctrl.reg_write = 1'b1;
				kind           = imm_j;
			end
			`OPC_JALR: begin // target is rs1 + imm through the alu
				ctrl.jalr      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				kind           = imm_i;
			end
			`OPC_BRANCH: begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = (funct3 != 3'b000);
				ctrl.alu_op    = alu_sub;  // zero flag means equal
				kind           = imm_b;
			end
			`OPC_LOAD: begin
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				kind           = imm_i;
			end
			`OPC_STORE: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				kind           = imm_s;
			end
			`OPC_OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = sel_op(funct3, alt, 1'b0);
				kind = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_i_shamt : imm_i;
			end
			`OPC_OP: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = sel_op(funct3, alt, 1'b1);
			end
			default: ; // unknown opcode leaves everything cleared
		endcase
	end

	// immediate assembly per format
	always_comb begin
		case (kind)
			imm_i:       imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
			imm_i_shamt: imm = {{(`XLEN-`SHAMT_W){1'b0}}, instr[20 +: `SHAMT_W]};
			imm_s:       imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
			imm_b: begin
				imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			imm_j: begin
				imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default:     imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// 31-entry register file, two combinational reads and one write, x0 tied to zero
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  riscv_pkg::reg_idx_t rs1,
	input  riscv_pkg::reg_idx_t rs2,
	input  riscv_pkg::reg_idx_t rd,
	input  logic                we,
	input  riscv_pkg::xlen_t    wdata,
	output riscv_pkg::xlen_t    rdata1,
	output riscv_pkg::xlen_t    rdata2
);
	import riscv_pkg::*;

	// no storage behind x0
	xlen_t regs [1:(2**$bits(reg_idx_t))-1];

	for (genvar i = 1; i < 2**$bits(reg_idx_t); i++) begin : g_reg
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				regs[i] <= '0;
			end else if (we && rd == reg_idx_t'(i)) begin
				regs[i] <= wdata;
			end
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	// a written value is held in its register for the next cycle's reads
	a_write_seen: assert property (@(posedge clk) disable iff (!rst_n)
		(we && rd != '0) |=> (regs[$past(rd)] == $past(wdata)))
		else $error("register write not visible in the following cycle");

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// nine-operation 64-bit alu with zero flag
`default_nettype none
`include "riscv_macros.svh"

module alu (
	input  riscv_pkg::alu_op_e op,
	input  riscv_pkg::xlen_t   a,
	input  riscv_pkg::xlen_t   b,
	output riscv_pkg::xlen_t   result,
	output logic               zero
);
	import riscv_pkg::*;

	logic [`SHAMT_W-1:0] shamt;

	assign shamt = b[`SHAMT_W-1:0];  // upper bits of b ignored for shifts

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_sll: result = a << shamt;
			alu_slt: result = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			alu_xor: result = a ^ b;
			alu_srl: result = a >> shamt;
			alu_sra: result = xlen_t'($signed(a) >>> shamt);  // keeps sign
			alu_or:  result = a | b;
			alu_and: result = a & b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/next_pc.sv ====
// program counter register with sequential, branch and jump selection
`default_nettype none

module next_pc (
	input  logic                  clk,
	input  logic                  rst_n,
	input  riscv_pkg::ctrl_t      ctrl,
	input  logic                  zero,
	input  riscv_pkg::xlen_t      imm,
	input  riscv_pkg::xlen_t      alu_result,
	output riscv_pkg::word_addr_t pc
);
	import riscv_pkg::*;

	word_addr_t pc_next;
	logic       taken;

	// beq on zero, bne on nonzero
	assign taken = ctrl.branch && (zero ^ ctrl.branch_ne);

	always_comb begin
		if (ctrl.jalr) begin
			pc_next = alu_result[$bits(word_addr_t)+1:2];  // rs1 + imm
		end else if (ctrl.jal || taken) begin
			pc_next = pc + imm[$bits(word_addr_t)+1:2];
		end else begin
			pc_next = pc + 1'b1;  // next word
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// fetch address must be known every cycle once out of reset
	a_pc_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(pc))
		else $error("pc went unknown");

endmodule

`default_nettype wire

// ==== source/riscv_core.sv ====
// single-cycle rv64 core top: byte swaps, operand and writeback muxes, submodules
`default_nettype none
`include "riscv_macros.svh"

module riscv_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  riscv_pkg::instr_t     mem_rdata_I,
	input  riscv_pkg::xlen_t      mem_rdata_D,
	output riscv_pkg::word_addr_t mem_addr_I,
	output riscv_pkg::word_addr_t mem_addr_D,
	output riscv_pkg::xlen_t      mem_wdata_D,
	output logic                  mem_wen_D
);
	import riscv_pkg::*;

	instr_t     instr;
	ctrl_t      ctrl;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	reg_idx_t   rd;
	xlen_t      imm;
	xlen_t      rdata1;
	xlen_t      rdata2;
	xlen_t      alu_b;
	xlen_t      alu_result;
	logic       zero;
	xlen_t      load_data;
	xlen_t      link;
	xlen_t      wb_data;
	word_addr_t pc;

	// memories are big-endian on the bus, core works little-endian
	assign instr       = {<<8{mem_rdata_I}};
	assign load_data   = {<<8{mem_rdata_D}};
	assign mem_wdata_D = {<<8{rdata2}};

	assign mem_addr_I = pc;
	assign mem_addr_D = alu_result[`PC_W+1:2];
	assign mem_wen_D  = ctrl.mem_write;

	assign alu_b = ctrl.alu_src ? imm : rdata2;
	assign link  = xlen_t'({pc, 2'b00}) + `XLEN'd4;  // byte pc + 4

	always_comb begin
		if (ctrl.jal || ctrl.jalr) begin
			wb_data = link;
		end else if (ctrl.mem_read) begin
			wb_data = load_data;
		end else begin
			wb_data = alu_result;
		end
	end

	instr_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd    (rd),
		.imm   (imm)
	);

	reg_file u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd     (rd),
		.we     (ctrl.reg_write),
		.wdata  (wb_data),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (rdata1),
		.b      (alu_b),
		.result (alu_result),
		.zero   (zero)
	);

	next_pc u_pc (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.zero       (zero),
		.imm        (imm),
		.alu_result (alu_result),
		.pc         (pc)
	);

endmodule

`default_nettype wire

// ==== tb/riscv_tb.sv ====
// testbench for riscv_core: clock, reset, instruction table with expected ports, checks, timeout
`default_nettype none

module riscv_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import riscv_pkg::*;

	// opcodes as the ISA defines them
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;

	typedef struct packed {
		instr_t     instr;       // normal bit order
		xlen_t      rdata_d;     // load data, normal byte order
		word_addr_t exp_pc;      // mem_addr_I after the edge
		logic       exp_wen;
		word_addr_t exp_addr_d;
		xlen_t      exp_wdata;   // register value, swapped before compare
	} row_t;

	logic       clk;
	logic       rst_n;
	instr_t     mem_rdata_I;
	xlen_t      mem_rdata_D;
	word_addr_t mem_addr_I;
	word_addr_t mem_addr_D;
	xlen_t      mem_wdata_D;
	logic       mem_wen_D;

	row_t rows[$];
	int   cycles = 0;
	int   cycle_limit = 100;  // replaced once the table is built

	riscv_core DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_rdata_I (mem_rdata_I),
		.mem_rdata_D (mem_rdata_D),
		.mem_addr_I  (mem_addr_I),
		.mem_addr_D  (mem_addr_D),
		.mem_wdata_D (mem_wdata_D),
		.mem_wen_D   (mem_wen_D)
	);

	always #5 clk = ~clk;

	// memories hold bytes in big-endian order
	function automatic instr_t swap_bytes32(input instr_t v);
		instr_t r;
		for (int b = 0; b < 4; b++) r[8*b +: 8] = v[8*(3-b) +: 8];
		return r;
	endfunction

	function automatic xlen_t swap_bytes64(input xlen_t v);
		xlen_t r;
		for (int b = 0; b < 8; b++) r[8*b +: 8] = v[8*(7-b) +: 8];
		return r;
	endfunction

	// small assembler for the formats in use
	function automatic instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};  // sd
	endfunction

	function automatic instr_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic instr_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic add_row(input instr_t instr, input xlen_t rdata_d, input word_addr_t exp_pc,
		input logic exp_wen, input word_addr_t exp_addr_d, input xlen_t exp_wdata);
		row_t r;
		r = '{instr, rdata_d, exp_pc, exp_wen, exp_addr_d, exp_wdata};
		rows.push_back(r);
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_addr(input word_addr_t got, input word_addr_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_data(input xlen_t got, input xlen_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// hand-worked program; PC of each row in the comment
	task automatic build_table();
		add_row(enc_i(op_imm, 3'b000, 1, 0, 100), 0, 1, 0, 0, 0);          // 0 addi x1,x0,100
		add_row(enc_i(op_imm, 3'b000, 2, 0, 12'hffd), 0, 2, 0, 0, 0);      // 1 addi x2,x0,-3
		add_row(enc_i(op_imm, 3'b001, 3, 1, {6'b000000, 6'd40}), 0, 3, 0, 0, 0); // 2 slli
		add_row(enc_i(op_imm, 3'b101, 4, 2, {6'b010000, 6'd1}), 0, 4, 0, 0, 0);  // 3 srai
		add_row(enc_i(op_imm, 3'b100, 5, 1, 12'h0f0), 0, 5, 0, 0, 0);      // 4 xori -> 0x94
		add_row(enc_r(7'b0000000, 5, 1, 3'b000, 6), 0, 6, 0, 0, 0);        // 5 add x6
		add_row(enc_s(8, 6, 0), 0, 7, 1, 2, 64'hf8);                       // 6 sd x6
		add_row(enc_r(7'b0100000, 5, 1, 3'b000, 7), 0, 8, 0, 0, 0);        // 7 sub x7
		add_row(enc_s(16, 7, 0), 0, 9, 1, 4, 64'hffff_ffff_ffff_ffd0);     // 8 sd x7
		add_row(enc_r(7'b0000000, 1, 2, 3'b010, 8), 0, 10, 0, 0, 0);       // 9 slt -3 < 100
		add_row(enc_s(24, 8, 1), 0, 11, 1, 31, 64'h1);                     // 10 sd x8,24(x1)
		add_row(enc_r(7'b0000000, 5, 1, 3'b111, 9), 0, 12, 0, 0, 0);       // 11 and
		add_row(enc_s(32, 9, 0), 0, 13, 1, 8, 64'h4);                      // 12 sd x9
		add_row(enc_r(7'b0000000, 5, 1, 3'b110, 10), 0, 14, 0, 0, 0);      // 13 or
		add_row(enc_s(40, 10, 0), 0, 15, 1, 10, 64'hf4);                   // 14 sd x10
		add_row(enc_r(7'b0000000, 1, 2, 3'b101, 11), 0, 16, 0, 0, 0);      // 15 srl by 100&63
		add_row(enc_s(48, 11, 0), 0, 17, 1, 12, 64'h0fff_ffff);            // 16 sd x11
		add_row(enc_r(7'b0100000, 8, 7, 3'b101, 12), 0, 18, 0, 0, 0);      // 17 sra x7 by 1
		add_row(enc_s(56, 12, 0), 0, 19, 1, 14, 64'hffff_ffff_ffff_ffe8);  // 18 sd x12
		add_row(enc_s(0, 3, 0), 0, 20, 1, 0, 64'h0000_6400_0000_0000);     // 19 sd x3
		add_row(enc_s(104, 4, 0), 0, 21, 1, 26, 64'hffff_ffff_ffff_fffe);  // 20 sd x4
		add_row(enc_i(op_load, 3'b011, 13, 0, 64), 64'h0123_4567_89ab_cdef,
			22, 0, 16, 0);                                                 // 21 ld x13
		add_row(enc_s(72, 13, 0), 0, 23, 1, 18, 64'h0123_4567_89ab_cdef);  // 22 sd x13
		add_row(enc_i(op_imm, 3'b000, 0, 1, 5), 0, 24, 0, 0, 0);           // 23 addi x0
		add_row(enc_s(80, 0, 0), 0, 25, 1, 20, 64'h0);                     // 24 sd x0
		add_row(enc_b(3'b000, 1, 1, 8), 0, 27, 0, 0, 0);                   // pc 25 beq taken
		add_row(enc_b(3'b001, 1, 1, 12), 0, 28, 0, 0, 0);                  // pc 27 bne not taken
		add_row(enc_b(3'b000, 1, 5, 16), 0, 29, 0, 0, 0);                  // pc 28 beq not taken
		add_row(enc_b(3'b001, 1, 5, 13'h1ff8), 0, 27, 0, 0, 0);            // pc 29 bne back
		add_row(enc_j(14, 20), 0, 32, 0, 0, 0);                            // pc 27 jal x14
		add_row(enc_s(88, 14, 0), 0, 33, 1, 22, 64'h70);                   // pc 32 link 27*4+4
		add_row(enc_i(op_jalr, 3'b000, 15, 1, 8), 0, 27, 0, 0, 0);         // pc 33 jalr 108
		add_row(enc_s(96, 15, 0), 0, 28, 1, 24, 64'h88);                   // pc 27 link 33*4+4
		add_row(enc_j(0, 21'h1ffff4), 0, 25, 0, 0, 0);                     // pc 28 jal -12
	endtask

	// guards against a stuck run
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		mem_rdata_I = '0;
		mem_rdata_D = '0;
		build_table();
		cycle_limit = rows.size() + 10 + 20;

		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		check_addr(mem_addr_I, '0, "mem_addr_I after reset");

		for (int i = 0; i < rows.size(); i++) begin
			mem_rdata_I = swap_bytes32(rows[i].instr);
			mem_rdata_D = swap_bytes64(rows[i].rdata_d);
			#3;  // combinational outputs settled
			check_bit(mem_wen_D, rows[i].exp_wen, $sformatf("row %0d mem_wen_D", i));
			if (rows[i].instr[6:0] == op_load || rows[i].instr[6:0] == op_store)
				check_addr(mem_addr_D, rows[i].exp_addr_d, $sformatf("row %0d mem_addr_D", i));
			if (rows[i].exp_wen)
				check_data(mem_wdata_D, swap_bytes64(rows[i].exp_wdata),
					$sformatf("row %0d mem_wdata_D", i));
			@(posedge clk);
			#1;
			check_addr(mem_addr_I, rows[i].exp_pc, $sformatf("row %0d mem_addr_I", i));
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/riscv_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/next_pc.sv
source/riscv_core.sv
tb/riscv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module riscv_tb -f flist.f -o riscv_sim \
	&& ./obj_dir/riscv_sim | tee /dev/stderr | grep "all tests passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }
